// File: source/ln_stats_pkg.sv
package ln_stats_pkg;

    // beat geometry
    localparam int lane_count = 8;
    localparam int beats_per_vector = 4;

    // 32 elements per vector, divide by shift
    localparam int vector_shift = 5;

    // register stages inside the eight-lane adder tree
    localparam int tree_latency = 2;

    // one input lane
    typedef logic signed [7:0] data_t;

    // one lane squared, (-128)^2 still fits
    typedef logic signed [15:0] square_t;

    // vector totals
    typedef logic signed [31:0] acc_t;

    // results
    typedef logic signed [7:0] mean_t;
    typedef logic [15:0] var_t;

    // position of a beat inside its vector
    typedef logic [1:0] beat_cnt_t;

endpackage

// File: source/beat_if.sv
interface beat_if;
    import ln_stats_pkg::*;

    data_t [lane_count-1:0] lanes;
    square_t [lane_count-1:0] squares;
    logic valid;
    logic last;
    logic first;

    modport producer (
        output lanes,
        output squares,
        output valid,
        output last,
        output first
    );

    modport consumer (
        input lanes,
        input squares,
        input valid,
        input last,
        input first
    );

endinterface

// File: source/beat_capture.sv
module beat_capture (
    input  logic clk,
    input  logic rstn,
    input  ln_stats_pkg::data_t [ln_stats_pkg::lane_count-1:0] in_data,
    input  logic in_valid,
    beat_if.producer beat
);
    import ln_stats_pkg::*;

    beat_cnt_t beat_cnt;

    // beat position, counting starts at reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
            beat.valid <= 1'b0;
            beat.first <= 1'b0;
            beat.last <= 1'b0;
        end else begin
            beat.valid <= in_valid;
            beat.first <= in_valid && (beat_cnt == '0);
            beat.last <= in_valid && (beat_cnt == beat_cnt_t'(beats_per_vector - 1));
            if (in_valid) begin
                if (beat_cnt == beat_cnt_t'(beats_per_vector - 1)) begin
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // lanes and their squares, held until the next valid beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            beat.lanes <= in_data;
            for (int i = 0; i < lane_count; i++) begin
                beat.squares[i] <= square_t'(in_data[i]) * square_t'(in_data[i]);
            end
        end
    end

    // both reducers key their vector boundary off last
    last_needs_valid: assert property (
        @(posedge clk) disable iff (!rstn)
        beat.last |-> beat.valid
    );

endmodule

// File: source/lane_reduce_acc.sv
module lane_reduce_acc #(
    parameter type lane_type = ln_stats_pkg::data_t,
    parameter bit use_squares = 1'b0
) (
    input  logic clk,
    input  logic rstn,
    beat_if.consumer beat,
    output ln_stats_pkg::acc_t total,
    output logic done
);
    import ln_stats_pkg::*;

    lane_type lane_sel [lane_count];
    lane_type lane_r [lane_count];
    acc_t level1 [lane_count/2];
    acc_t level2 [lane_count/4];
    acc_t level2_r [lane_count/4];
    acc_t tree_sum;
    acc_t acc;
    logic s0_valid;
    logic s0_first;
    logic s0_last;
    logic s1_valid;
    logic s1_first;
    logic s1_last;

    // pick the field this instance reduces
    if (use_squares) begin : g_squares
        always_comb begin
            for (int i = 0; i < lane_count; i++) begin
                lane_sel[i] = lane_type'(beat.squares[i]);
            end
        end
    end else begin : g_lanes
        always_comb begin
            for (int i = 0; i < lane_count; i++) begin
                lane_sel[i] = lane_type'(beat.lanes[i]);
            end
        end
    end

    // input level register
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            lane_r <= lane_sel;
        end
    end

    // levels one and two are combinational
    always_comb begin
        for (int j = 0; j < lane_count/2; j++) begin
            level1[j] = acc_t'(lane_r[2*j]) + acc_t'(lane_r[2*j+1]);
        end
        for (int k = 0; k < lane_count/4; k++) begin
            level2[k] = level1[2*k] + level1[2*k+1];
        end
    end

    // register after level two
    always_ff @(posedge clk) begin
        if (s0_valid) begin
            level2_r <= level2;
        end
    end

    assign tree_sum = level2_r[0] + level2_r[1];

    // beat flags follow the tree registers
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s0_valid <= 1'b0;
            s0_first <= 1'b0;
            s0_last <= 1'b0;
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last <= 1'b0;
        end else begin
            s0_valid <= beat.valid;
            s0_first <= beat.first;
            s0_last <= beat.last;
            s1_valid <= s0_valid;
            s1_first <= s0_first;
            s1_last <= s0_last;
        end
    end

    // first beat reloads, so the next vector can follow with no gap
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc <= '0;
            done <= 1'b0;
        end else begin
            done <= s1_valid && s1_last;
            if (s1_valid) begin
                acc <= s1_first ? tree_sum : acc + tree_sum;
            end
        end
    end

    assign total = acc;

    done_single_pulse: assert property (
        @(posedge clk) disable iff (!rstn)
        done |=> !done
    );

endmodule

// File: source/stats_combine.sv
module stats_combine (
    input  logic clk,
    input  logic rstn,
    input  ln_stats_pkg::acc_t sum,
    input  logic sum_done,
    input  ln_stats_pkg::acc_t sumsq,
    input  logic sumsq_done,
    output ln_stats_pkg::mean_t stats_mean,
    output ln_stats_pkg::var_t stats_var,
    output logic stats_valid
);
    import ln_stats_pkg::*;

    acc_t mean_wide;
    mean_t mean_next;
    acc_t sumsq_div;
    acc_t mean_sq;
    acc_t var_diff;
    var_t var_next;

    // floor division for both moments, then E[x^2] - mean^2
    always_comb begin
        mean_wide = sum >>> vector_shift;
        mean_next = mean_t'(mean_wide);
        sumsq_div = sumsq >>> vector_shift;
        mean_sq = acc_t'(mean_next) * acc_t'(mean_next);
        var_diff = sumsq_div - mean_sq;
        // floored mean can push this below zero
        var_next = (var_diff < 0) ? '0 : var_t'(var_diff);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stats_valid <= 1'b0;
        end else begin
            stats_valid <= sum_done && sumsq_done;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_done) begin
            stats_mean <= mean_next;
            stats_var <= var_next;
        end
    end

    // the two reducers run in lockstep
    reducers_aligned: assert property (
        @(posedge clk) disable iff (!rstn)
        sum_done == sumsq_done
    );

endmodule

// File: source/ln_stats_top.sv
module ln_stats_top (
    input  logic clk,
    input  logic rstn,
    input  logic [ln_stats_pkg::lane_count*8-1:0] in_data,
    input  logic in_valid,
    output ln_stats_pkg::mean_t stats_mean,
    output ln_stats_pkg::var_t stats_var,
    output logic stats_valid
);
    import ln_stats_pkg::*;

    acc_t sum_total;
    acc_t sumsq_total;
    logic sum_done;
    logic sumsq_done;

    beat_if beat ();

    beat_capture u_capture (
        .clk      (clk),
        .rstn     (rstn),
        .in_data  (in_data),
        .in_valid (in_valid),
        .beat     (beat.producer)
    );

    lane_reduce_acc #(
        .lane_type   (data_t),
        .use_squares (1'b0)
    ) sum_reduce (
        .clk   (clk),
        .rstn  (rstn),
        .beat  (beat.consumer),
        .total (sum_total),
        .done  (sum_done)
    );

    lane_reduce_acc #(
        .lane_type   (square_t),
        .use_squares (1'b1)
    ) sumsq_reduce (
        .clk   (clk),
        .rstn  (rstn),
        .beat  (beat.consumer),
        .total (sumsq_total),
        .done  (sumsq_done)
    );

    stats_combine u_combine (
        .clk         (clk),
        .rstn        (rstn),
        .sum         (sum_total),
        .sum_done    (sum_done),
        .sumsq       (sumsq_total),
        .sumsq_done  (sumsq_done),
        .stats_mean  (stats_mean),
        .stats_var   (stats_var),
        .stats_valid (stats_valid)
    );

endmodule

// File: verification/tb_ln_stats.sv
module tb_ln_stats;
    import ln_stats_pkg::*;

    localparam int random_vectors = 6;
    localparam int total_beats = (2 * random_vectors + 4) * beats_per_vector;
    // leaves room for up to three idle cycles per beat
    localparam int cycle_limit = 4 * total_beats + 100;
    localparam int drain_cycles = 12;
    localparam int result_latency = 5;

    logic clk;
    logic rstn;
    logic [lane_count*8-1:0] in_data;
    logic in_valid;
    mean_t stats_mean;
    var_t stats_var;
    logic stats_valid;

    // fourth beat of a vector on the inputs
    logic last_beat;
    logic checked_valid;

    int seed;
    int cycle_count = 0;
    int beat_pos;
    int vec_elems [beats_per_vector*lane_count];
    logic [lane_count*8-1:0] saved_beats [random_vectors*beats_per_vector];
    mean_t mean_q [$];
    var_t var_q [$];
    mean_t head_mean;
    var_t head_var;
    int pending;
    string test_name;
    int mean_errors;
    int var_errors;
    int protocol_errors;

    ln_stats_top uut (
        .clk         (clk),
        .rstn        (rstn),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .stats_mean  (stats_mean),
        .stats_var   (stats_var),
        .stats_valid (stats_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic refresh_head();
        pending = mean_q.size();
        if (pending > 0) begin
            head_mean = mean_q[0];
            head_var = var_q[0];
        end
    endtask

    // floor mean by shift, E[x^2] - mean^2 clamped at zero
    task automatic push_expected();
        int sum;
        int sumsq;
        int mean;
        int variance;
        sum = 0;
        sumsq = 0;
        for (int i = 0; i < beats_per_vector * lane_count; i++) begin
            sum += vec_elems[i];
            sumsq += vec_elems[i] * vec_elems[i];
        end
        mean = sum >>> vector_shift;
        variance = (sumsq >>> vector_shift) - mean * mean;
        if (variance < 0) begin
            variance = 0;
        end
        mean_q.push_back(mean_t'(mean));
        var_q.push_back(var_t'(variance));
        refresh_head();
    endtask

    task automatic record_beat(input logic [lane_count*8-1:0] word);
        for (int i = 0; i < lane_count; i++) begin
            vec_elems[beat_pos*lane_count + i] = int'(data_t'(word[8*i +: 8]));
        end
        if (beat_pos == beats_per_vector - 1) begin
            push_expected();
            beat_pos = 0;
        end else begin
            beat_pos++;
        end
    endtask

    task automatic send_beat(input logic [lane_count*8-1:0] word);
        @(negedge clk);
        in_data = word;
        in_valid = 1'b1;
        last_beat = (beat_pos == beats_per_vector - 1);
        record_beat(word);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        last_beat = 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        idle_cycle();
        while (pending > 0 && waited < drain_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (pending > 0) begin
            protocol_errors++;
            $display("%s: %0d vectors never produced a result", test_name, pending);
        end
    endtask

    task automatic send_fill(input data_t value);
        repeat (beats_per_vector) send_beat({lane_count{value}});
        wait_results();
    endtask

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            checked_valid <= 1'b0;
        end else begin
            checked_valid <= stats_valid;
        end
    end

    // retire the entry the checks compared at the last rising edge
    always @(negedge clk) begin
        if (checked_valid && mean_q.size() > 0) begin
            mean_q.delete(0);
            var_q.delete(0);
            refresh_head();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run stopped after %0d cycles, results never arrived", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    result_expected: assert property (
        @(posedge clk) disable iff (!rstn)
        stats_valid |-> pending > 0
    ) else begin
        protocol_errors++;
        $display("%s: stats_valid rose with no vector outstanding", test_name);
    end

    mean_matches: assert property (
        @(posedge clk) disable iff (!rstn)
        stats_valid && pending > 0 |-> stats_mean == head_mean
    ) else begin
        mean_errors++;
        $display("** Error %s: mean expected %0d, actual %0d", test_name, head_mean, stats_mean);
    end

    var_matches: assert property (
        @(posedge clk) disable iff (!rstn)
        stats_valid && pending > 0 |-> stats_var == head_var
    ) else begin
        var_errors++;
        $display("** Error %s: variance expected %0d, actual %0d", test_name, head_var,
            stats_var);
    end

    latency_fixed: assert property (
        @(posedge clk) disable iff (!rstn)
        stats_valid == $past(in_valid && last_beat, result_latency)
    ) else begin
        protocol_errors++;
        $display("%s: stats_valid did not follow the last beat by exactly %0d cycles",
            test_name, result_latency);
    end

    initial begin
        int gap;
        rstn = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        last_beat = 1'b0;
        seed = 32'hfb6d0b8f;
        beat_pos = 0;
        pending = 0;
        head_mean = '0;
        head_var = '0;
        mean_errors = 0;
        var_errors = 0;
        protocol_errors = 0;
        test_name = "reset";
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        test_name = "idle_after_reset";
        repeat (20) @(negedge clk);

        test_name = "constant_37";
        send_fill(8'sd37);

        test_name = "random_back_to_back";
        for (int b = 0; b < random_vectors * beats_per_vector; b++) begin
            saved_beats[b] = {$random(seed), $random(seed)};
            send_beat(saved_beats[b]);
        end
        wait_results();

        // same beats again, idle cycles must not count
        test_name = "random_with_gaps";
        for (int b = 0; b < random_vectors * beats_per_vector; b++) begin
            send_beat(saved_beats[b]);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) idle_cycle();
        end
        wait_results();

        test_name = "alternating_neg";
        repeat (beats_per_vector) send_beat({lane_count/2{8'hfe, 8'hff}});
        wait_results();

        test_name = "all_min";
        send_fill(8'sh80);
        test_name = "all_max";
        send_fill(8'sh7f);

        $display("errors: mean %0d, variance %0d, protocol %0d",
            mean_errors, var_errors, protocol_errors);
        if (mean_errors + var_errors + protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
source/ln_stats_pkg.sv
source/beat_if.sv
source/beat_capture.sv
source/lane_reduce_acc.sv
source/stats_combine.sv
source/ln_stats_top.sv
verification/tb_ln_stats.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert -f compile.f --top-module tb_ln_stats \
    -Mdir "$build_dir" -o sim_ln_stats
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim_ln_stats" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Result: FAILED" "$log_file"; then
    exit 1
fi
exit 0
